//--- flist.f
fpu_pkg.sv
fpu_req_if.sv
fpu_decoder.sv
fpu_step_counter.sv
fpu_ctrl_fsm.sv
fpu_noncomp_unit.sv
fpu_mul_iter.sv
fpu_exe_top.sv
tb_fpu_exe_properties.sv
tb_fpu_exe.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the FP32 execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f flist.f \
   --top-module tb_fpu_exe -Mdir obj_dir -o sim_fpu
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/sim_fpu > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi
if grep -q "Some tests failed" "$LOG"; then
   exit 1
fi
if ! grep -q "All tests passed" "$LOG"; then
   echo "Simulation ended without a verdict"
   exit 1
fi
exit 0

//--- tb_fpu_exe.sv
/*
 * Testbench for the FP32 execute stage. Drives inputs 1 ns after the rising
 * edge and samples there too, so every DUT output has settled.
 * FMUL stimulus uses normal operands with exponents 64 to 190 only.
 */
`timescale 1ns/1ns
`default_nettype none

module tb_fpu_exe import fpu_pkg::*; ();

   localparam int WAIT_LIMIT = MUL_STEPS + 20;   // Longest legal wait plus slack

   logic            clk_i, rstn_i, kill_i, in_valid_i, out_ready_i;
   logic            in_ready_o, out_valid_o, int_dest_o;
   instr_type_e     instr_type_i;
   logic [XLEN-1:0] rs1_i, rs2_i, result_o;
   logic [4:0]      rd_i, rd_o;

   int          checks, errors, tests, chk_mark, err_mark;
   string       test_name;
   logic [31:0] pair_a [16];
   logic [31:0] pair_b [16];
   // Directed pairs with signed zeros, NaNs, infinities and a subnormal
   logic [31:0] fixed_a [8] = '{32'h3f80_0000, 32'hc040_0000, 32'h8000_0000, 32'h7fc0_0000,
                                32'hbf80_0000, 32'h7fc0_0000, 32'h4120_0000, 32'hff80_0000};
   logic [31:0] fixed_b [8] = '{32'h4000_0000, 32'h3f00_0000, 32'h0000_0000, 32'h3f80_0000,
                                32'h7f80_0001, 32'hff80_0001, 32'h4120_0000, 32'h0000_0001};
   instr_type_e nc_ops [7] = '{FSGNJ, FSGNJN, FSGNJX, FMIN, FMAX, FMV_X2F, FMV_F2X};
   instr_type_e mix_ops [11] = '{FSGNJ, FSGNJN, FSGNJX, FMIN, FMAX, FEQ, FLT, FLE,
                                 FMV_X2F, FMV_F2X, FMUL};
   // -inf, -norm, -sub, -0, +0, +sub, +norm, +inf, sNaN, qNaN
   logic [31:0] class_vec [10] = '{32'hff80_0000, 32'hbf80_0000, 32'h8000_0001,
                                   32'h8000_0000, 32'h0000_0000, 32'h0000_0001,
                                   32'h3f80_0000, 32'h7f80_0000, 32'h7f80_0001,
                                   32'h7fc0_0000};

   fpu_exe_top dut (.*);

   initial begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   // ------------------------------
   // Reference model
   // ------------------------------
   function automatic logic is_nan(input logic [31:0] x);
      return (&x[30:23]) && (|x[22:0]);
   endfunction

   // Signed magnitude to two's complement, both zeros map to 0
   function automatic logic signed [32:0] order_key(input logic [31:0] x);
      logic signed [32:0] mag;
      mag = {2'b00, x[30:0]};
      return x[31] ? -mag : mag;
   endfunction

   function automatic logic [31:0] mul_ref(input logic [31:0] a, input logic [31:0] b);
      logic        s;
      logic [47:0] p;
      logic [22:0] m;
      int          e;
      s = a[31] ^ b[31];
      if (a[30:23] == 8'd0 || b[30:23] == 8'd0) return {s, 31'd0};
      p = 48'({1'b1, a[22:0]}) * 48'({1'b1, b[22:0]});
      e = int'(a[30:23]) + int'(b[30:23]) - EXP_BIAS;
      if (p[47]) begin
         m = p[46:24];
         e = e + 1;
      end else begin
         m = p[45:23];
      end
      if (e <= 0) return {s, 31'd0};
      if (e >= 255) return {s, 8'hff, 23'd0};
      return {s, 8'(e), m};
   endfunction

   function automatic logic [31:0] ref_result(input instr_type_e t, input logic [31:0] a,
                                              input logic [31:0] b);
      logic a_first;
      logic ordered;
      a_first = (order_key(a) < order_key(b))
                || (order_key(a) == order_key(b) && a[31] && !b[31]);
      ordered = !is_nan(a) && !is_nan(b);
      case (t)
         FSGNJ:  return {b[31], a[30:0]};
         FSGNJN: return {~b[31], a[30:0]};
         FSGNJX: return {a[31] ^ b[31], a[30:0]};
         FMIN, FMAX: begin
            if (is_nan(a) && is_nan(b)) return 32'h7fc0_0000;
            if (is_nan(a)) return b;
            if (is_nan(b)) return a;
            return ((t == FMIN) == a_first) ? a : b;
         end
         FEQ:    return {31'd0, ordered && order_key(a) == order_key(b)};
         FLT:    return {31'd0, ordered && order_key(a) < order_key(b)};
         FLE:    return {31'd0, ordered && order_key(a) <= order_key(b)};
         FMUL:   return mul_ref(a, b);
         default: return a;   // Moves
      endcase
   endfunction

   function automatic logic [31:0] rand_normal();
      logic [7:0] e;
      e = 8'(64 + $urandom_range(126));
      return {1'($urandom), e, 23'($urandom)};
   endfunction

   // ------------------------------
   // Checking and bus tasks
   // ------------------------------
   task automatic abort_run(input string why);
      $display("%s at %0t", why, $time);
      $display("Some tests failed");
      $finish;
   endtask

   task automatic expect_true(input logic ok, input string msg);
      checks++;
      assert (ok) else begin
         errors++;
         $display("Fail %0t: %s", $time, msg);
      end
   endtask

   task automatic begin_test(input string name);
      test_name = name;
      chk_mark  = checks;
      err_mark  = errors;
   endtask

   task automatic end_test();
      tests++;
      $display("%s: %0d checks, %0d errors", test_name, checks - chk_mark, errors - err_mark);
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) begin
         @(posedge clk_i);
         #1;
      end
   endtask

   // Holds the request until in_ready_o, returns just after the accept edge
   task automatic send_instr(input instr_type_e t, input logic [31:0] a,
                             input logic [31:0] b, input logic [4:0] rd);
      int n;
      instr_type_i = t;
      rs1_i        = a;
      rs2_i        = b;
      rd_i         = rd;
      in_valid_i   = 1'b1;
      n = 0;
      while (!in_ready_o) begin
         wait_cycles(1);
         n++;
         if (n > WAIT_LIMIT) abort_run("Timeout waiting for in_ready_o");
      end
      wait_cycles(1);
      in_valid_i = 1'b0;
   endtask

   // cycles counts edges from accept to the first edge with out_valid_o high
   task automatic collect_result(input int hold, output logic [31:0] res,
                                 output logic [4:0] rd, output logic intd, output int cycles);
      cycles = 1;
      while (!out_valid_o) begin
         wait_cycles(1);
         cycles++;
         if (cycles > WAIT_LIMIT) abort_run("Timeout waiting for out_valid_o");
      end
      res  = result_o;
      rd   = rd_o;
      intd = int_dest_o;
      repeat (hold) begin
         wait_cycles(1);
         expect_true(out_valid_o && result_o == res && rd_o == rd && int_dest_o == intd,
                     "output changed under back-pressure");
         expect_true(!in_ready_o, "in_ready_o high while a result is held");
      end
      out_ready_i = 1'b1;
      wait_cycles(1);
      out_ready_i = 1'b0;
      expect_true(!out_valid_o && in_ready_o, "stage not idle after retire");
   endtask

   task automatic issue_and_compare(input instr_type_e t, input logic [31:0] a,
                                    input logic [31:0] b, input int hold,
                                    input logic [31:0] exp);
      logic [31:0] res;
      logic [4:0]  rd, rd_got;
      logic        intd;
      int          cycles;
      rd = 5'($urandom);
      send_instr(t, a, b, rd);
      collect_result(hold, res, rd_got, intd, cycles);
      expect_true(res == exp, $sformatf("%s a=%h b=%h result %h expected %h",
                                        t.name(), a, b, res, exp));
      expect_true(rd_got == rd, $sformatf("%s rd %0d expected %0d", t.name(), rd_got, rd));
      expect_true(intd == (t inside {FEQ, FLT, FLE, FCLASS, FMV_F2X}),
                  $sformatf("%s int_dest %b", t.name(), intd));
      expect_true(cycles == ((t == FMUL) ? MUL_STEPS + 1 : 1),
                  $sformatf("%s latency %0d cycles", t.name(), cycles));
   endtask

   // Global limit on simulated time
   initial begin
      #2_000_000;
      abort_run("Simulation time limit reached");
   end

   // ------------------------------
   // Test sequence
   // ------------------------------
   initial begin
      int i, j;
      instr_type_e t;
      logic [31:0] a, b;
      void'($urandom(32'h3894_5676));
      checks = 0;
      errors = 0;
      tests  = 0;
      rstn_i = 1'b0;
      kill_i = 1'b0;
      in_valid_i   = 1'b0;
      out_ready_i  = 1'b0;
      instr_type_i = INSTR_NONE;
      rs1_i = '0;
      rs2_i = '0;
      rd_i  = '0;
      for (i = 0; i < 8; i++) begin
         pair_a[i] = fixed_a[i];
         pair_b[i] = fixed_b[i];
      end
      for (i = 8; i < 16; i++) begin
         pair_a[i] = $urandom;
         pair_b[i] = (i % 2 == 0) ? pair_a[i] ^ 32'h8000_0000 : $urandom;
      end
      repeat (2) @(posedge clk_i);
      #1;
      rstn_i = 1'b1;
      expect_true(in_ready_o && !out_valid_o, "handshake wrong after reset");

      begin_test("Sign injection, min/max and moves");
      for (i = 0; i < 16; i++) begin
         for (j = 0; j < 7; j++) begin
            issue_and_compare(nc_ops[j], pair_a[i], pair_b[i], 0,
                              ref_result(nc_ops[j], pair_a[i], pair_b[i]));
         end
      end
      end_test();

      begin_test("Compares and classify");
      for (i = 0; i < 16; i++) begin
         issue_and_compare(FEQ, pair_a[i], pair_b[i], 0, ref_result(FEQ, pair_a[i], pair_b[i]));
         issue_and_compare(FLT, pair_a[i], pair_b[i], 0, ref_result(FLT, pair_a[i], pair_b[i]));
         issue_and_compare(FLE, pair_a[i], pair_b[i], 0, ref_result(FLE, pair_a[i], pair_b[i]));
      end
      for (i = 0; i < 10; i++) begin
         issue_and_compare(FCLASS, class_vec[i], $urandom, 0, 32'd1 << i);
      end
      end_test();

      begin_test("Random FMUL");
      for (i = 0; i < 200; i++) begin
         a = rand_normal();
         b = rand_normal();
         issue_and_compare(FMUL, a, b, 0, mul_ref(a, b));
      end
      end_test();

      begin_test("Back-pressure");
      for (i = 0; i < 30; i++) begin
         t = mix_ops[$urandom_range(10)];
         a = rand_normal();
         b = rand_normal();
         issue_and_compare(t, a, b, $urandom_range(1, 8), ref_result(t, a, b));
      end
      end_test();

      begin_test("Kill during FMUL");
      for (i = 0; i < 8; i++) begin
         send_instr(FMUL, rand_normal(), rand_normal(), 5'd31);
         wait_cycles($urandom_range(0, 20));
         kill_i = 1'b1;
         wait_cycles(1);
         kill_i = 1'b0;
         expect_true(!out_valid_o && in_ready_o, "stage not idle after kill");
         for (j = 0; j < MUL_STEPS + 4; j++) begin
            wait_cycles(1);
            expect_true(!out_valid_o, "killed FMUL produced a result");
         end
         a = rand_normal();
         b = rand_normal();
         issue_and_compare(FMUL, a, b, 0, mul_ref(a, b));
         issue_and_compare(FSGNJX, b, a, 0, ref_result(FSGNJX, b, a));
      end
      end_test();

      $display("Tests run: %0d, checks: %0d, errors: %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- tb_fpu_exe_properties.sv
/*
 * Handshake properties of the FP32 execute stage, bound into fpu_exe_top.
 * Reads the control state by hierarchy from the u_ctrl instance.
 */
`timescale 1ns/1ns
`default_nettype none

module tb_fpu_exe_properties import fpu_pkg::*; (
   input logic            clk_i,
   input logic            rstn_i,
   input logic            kill_i,
   input logic            in_valid_i,
   input logic            in_ready_i,
   input logic            out_valid_i,
   input logic            out_ready_i,
   input logic [XLEN-1:0] result_i,
   input logic [4:0]      rd_i,
   input logic            int_dest_i,
   input ctrl_state_e     state_i
);

   logic pending_q;   // Accepted and not yet retired or killed

   always_ff @(posedge clk_i, negedge rstn_i) begin
      if (!rstn_i) begin
         pending_q <= 1'b0;
      end else if (kill_i) begin
         pending_q <= 1'b0;
      end else if (in_valid_i && in_ready_i) begin
         pending_q <= 1'b1;
      end else if (out_valid_i && out_ready_i) begin
         pending_q <= 1'b0;
      end
   end

   a_ready_valid_excl: assert property (@(posedge clk_i) disable iff (!rstn_i)
      !(in_ready_i && out_valid_i))
      else $error("in_ready and out_valid high together");

   a_hold_stable: assert property (@(posedge clk_i) disable iff (!rstn_i)
      out_valid_i && !out_ready_i && !kill_i |=>
         out_valid_i && $stable(result_i) && $stable(rd_i) && $stable(int_dest_i))
      else $error("output changed under back-pressure");

   // Kill also blocks an instruction offered in the same cycle
   a_kill_drops: assert property (@(posedge clk_i) disable iff (!rstn_i)
      kill_i |=> !out_valid_i && state_i == ST_IDLE)
      else $error("out_valid still high or state not idle after kill");

   a_valid_needs_accept: assert property (@(posedge clk_i) disable iff (!rstn_i)
      out_valid_i |-> pending_q)
      else $error("out_valid without an accepted instruction");

endmodule

bind fpu_exe_top tb_fpu_exe_properties props (
   .clk_i       (clk_i),
   .rstn_i      (rstn_i),
   .kill_i      (kill_i),
   .in_valid_i  (in_valid_i),
   .in_ready_i  (in_ready_o),
   .out_valid_i (out_valid_o),
   .out_ready_i (out_ready_i),
   .result_i    (result_o),
   .rd_i        (rd_o),
   .int_dest_i  (int_dest_o),
   .state_i     (u_ctrl.state_q)
);

`default_nettype wire

//--- fpu_exe_top.sv
/*
 * FP32 execute stage with valid/ready on both sides, one instruction in flight.
 * The issue side holds its inputs until in_ready_o. kill_i drops the
 * instruction in flight on the next edge.
 */
`timescale 1ns/1ns
`default_nettype none

module fpu_exe_top import fpu_pkg::*; (
   input  logic            clk_i,
   input  logic            rstn_i,
   input  logic            kill_i,
   // Issue side
   input  logic            in_valid_i,
   output logic            in_ready_o,
   input  instr_type_e     instr_type_i,
   input  logic [XLEN-1:0] rs1_i,
   input  logic [XLEN-1:0] rs2_i,
   input  logic [4:0]      rd_i,
   // Writeback side
   output logic            out_valid_o,
   input  logic            out_ready_i,
   output logic [XLEN-1:0] result_o,
   output logic [4:0]      rd_o,
   output logic            int_dest_o
);

   fpu_req_if req_if ();

   logic            count_en, step_last, mul_done, sel_mul;
   logic [XLEN-1:0] nc_result, mul_result;

   assign req_if.opa = rs1_i;
   assign req_if.opb = rs2_i;

   fpu_decoder u_dec (
      .instr_type_i (instr_type_i),
      .req          (req_if.dec)
   );

   fpu_ctrl_fsm u_ctrl (
      .clk_i        (clk_i),
      .rstn_i       (rstn_i),
      .in_valid_i   (in_valid_i),
      .in_ready_o   (in_ready_o),
      .out_valid_o  (out_valid_o),
      .out_ready_i  (out_ready_i),
      .kill_i       (kill_i),
      .req          (req_if.ctrl),
      .step_last_i  (step_last),
      .mul_done_i   (mul_done),
      .count_en_o   (count_en),
      .sel_mul_o    (sel_mul)
   );

   fpu_step_counter u_cnt (
      .clk_i        (clk_i),
      .rstn_i       (rstn_i),
      .clear_i      (req_if.start | req_if.kill),
      .count_en_i   (count_en),
      .last_o       (step_last)
   );

   fpu_noncomp_unit u_noncomp (
      .clk_i        (clk_i),
      .rstn_i       (rstn_i),
      .req          (req_if.dp),
      .result_o     (nc_result)
   );

   fpu_mul_iter u_mul (
      .clk_i        (clk_i),
      .rstn_i       (rstn_i),
      .req          (req_if.dp),
      .step_en_i    (count_en),
      .step_last_i  (step_last),
      .mul_done_o   (mul_done),
      .result_o     (mul_result)
   );

   // Destination travels with the instruction
   always_ff @(posedge clk_i) begin
      if (req_if.start) begin
         rd_o       <= rd_i;
         int_dest_o <= req_if.int_dest;
      end
   end

   assign result_o = sel_mul ? mul_result : nc_result;

endmodule

`default_nettype wire

//--- fpu_mul_iter.sv
/*
 * Sequential FP32 multiplier, one multiplier bit per step, LSB first.
 * Truncates the product. Subnormal inputs count as zero, underflow flushes
 * to zero and overflow saturates to infinity. NaN and infinity inputs give
 * an undefined result.
 */
`timescale 1ns/1ns
`default_nettype none

module fpu_mul_iter import fpu_pkg::*; (
   input  logic            clk_i,
   input  logic            rstn_i,
   fpu_req_if.dp           req,
   input  logic            step_en_i,
   input  logic            step_last_i,
   output logic            mul_done_o,
   output logic [XLEN-1:0] result_o
);

   logic [MAN_W:0]     mant_a_q;
   logic [2*MAN_W+1:0] prod_q;      // Upper half accumulates, lower half shifts out b
   logic [EXP_W+1:0]   exp_q;       // Two's complement, two guard bits
   logic               sign_q, zero_q, busy_q;

   logic               load, step, norm;
   logic [MAN_W+1:0]   part_sum;
   logic [2*MAN_W+1:0] prod_d;
   logic [EXP_W+1:0]   exp_n;
   logic [MAN_W-1:0]   man_n;
   logic [XLEN-1:0]    res_n;

   assign load       = req.start & (req.op_class == OPC_MUL);
   assign step       = step_en_i & busy_q;
   assign mul_done_o = step & step_last_i;   // Product lands on this edge

   // ------------------------------
   // Add and shift one bit
   // ------------------------------
   assign part_sum = {1'b0, prod_q[2*MAN_W+1:MAN_W+1]} + (prod_q[0] ? {1'b0, mant_a_q} : '0);
   assign prod_d   = {part_sum, prod_q[MAN_W:1]};

   // Normalise by at most one bit, then truncate
   assign norm  = prod_d[2*MAN_W+1];
   assign man_n = norm ? prod_d[2*MAN_W:MAN_W+1] : prod_d[2*MAN_W-1:MAN_W];
   assign exp_n = exp_q + {{(EXP_W+1){1'b0}}, norm};

   always_comb begin
      if (zero_q || exp_n[EXP_W+1] || exp_n == '0) begin
         res_n = {sign_q, {(FLEN-1){1'b0}}};                    // Flush to zero
      end else if (exp_n[EXP_W] || (&exp_n[EXP_W-1:0])) begin
         res_n = {sign_q, {EXP_W{1'b1}}, {MAN_W{1'b0}}};        // Saturate to inf
      end else begin
         res_n = {sign_q, exp_n[EXP_W-1:0], man_n};
      end
   end

   always_ff @(posedge clk_i, negedge rstn_i) begin
      if (!rstn_i) begin
         busy_q <= 1'b0;
      end else if (req.kill || mul_done_o) begin
         busy_q <= 1'b0;
      end else if (load) begin
         busy_q <= 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (load) begin
         mant_a_q <= {1'b1, req.opa[MAN_W-1:0]};
         prod_q   <= {{(MAN_W+1){1'b0}}, 1'b1, req.opb[MAN_W-1:0]};
         exp_q    <= {2'b00, req.opa[FLEN-2:MAN_W]} + {2'b00, req.opb[FLEN-2:MAN_W]}
                     - (EXP_W+2)'(EXP_BIAS);
         sign_q   <= req.opa[FLEN-1] ^ req.opb[FLEN-1];
         zero_q   <= ~|req.opa[FLEN-2:MAN_W] | ~|req.opb[FLEN-2:MAN_W];
      end else if (step) begin
         prod_q <= prod_d;
      end
      if (mul_done_o) result_o <= res_n;
   end

endmodule

`default_nettype wire

//--- fpu_noncomp_unit.sv
/*
 * Non-computational FP32 operations with a fixed one-cycle latency.
 * Compare, min/max and classify follow the RISC-V rules, subnormals included.
 * Min/max returns the canonical NaN only when both inputs are NaN.
 */
`timescale 1ns/1ns
`default_nettype none

module fpu_noncomp_unit import fpu_pkg::*; (
   input  logic            clk_i,
   input  logic            rstn_i,
   fpu_req_if.dp           req,
   output logic [XLEN-1:0] result_o
);

   logic               a_sign, b_sign;
   logic               a_exp_max, a_exp_zero, a_man_zero;
   logic               a_nan, b_nan, a_zero, b_zero, any_nan;
   logic [FLEN-2:0]    a_mag, b_mag;
   logic               lt_tot, feq, flt, fle;
   logic [CLASS_W-1:0] class_mask;
   logic [XLEN-1:0]    res_d;

   assign a_sign = req.opa[FLEN-1];
   assign b_sign = req.opb[FLEN-1];
   assign a_mag  = req.opa[FLEN-2:0];
   assign b_mag  = req.opb[FLEN-2:0];

   assign a_exp_max  = &req.opa[FLEN-2:MAN_W];
   assign a_exp_zero = ~|req.opa[FLEN-2:MAN_W];
   assign a_man_zero = ~|req.opa[MAN_W-1:0];

   assign a_nan   = a_exp_max & ~a_man_zero;
   assign b_nan   = (&req.opb[FLEN-2:MAN_W]) & (|req.opb[MAN_W-1:0]);
   assign a_zero  = a_exp_zero & a_man_zero;
   assign b_zero  = ~|b_mag;
   assign any_nan = a_nan | b_nan;

   // Ordering ignoring NaN, with -0 below +0 for min/max
   assign lt_tot = (a_sign != b_sign) ? a_sign
                 : (a_sign ? (a_mag > b_mag) : (a_mag < b_mag));

   assign feq = ~any_nan & ((req.opa == req.opb) | (a_zero & b_zero));
   assign flt = ~any_nan & lt_tot & ~(a_zero & b_zero);
   assign fle = flt | feq;

   // ------------------------------
   // FCLASS mask of operand a
   // ------------------------------
   always_comb begin
      class_mask = '0;
      if (a_nan)                         class_mask[req.opa[MAN_W-1] ? 9 : 8] = 1'b1;
      else if (a_exp_max)                class_mask[a_sign ? 0 : 7] = 1'b1;   // Infinity
      else if (a_zero)                   class_mask[a_sign ? 3 : 4] = 1'b1;
      else if (a_exp_zero)               class_mask[a_sign ? 2 : 5] = 1'b1;   // Subnormal
      else                               class_mask[a_sign ? 1 : 6] = 1'b1;
   end

   always_comb begin
      case (req.noncomp_op)
         NC_SGNJ:  res_d = {b_sign, a_mag};
         NC_SGNJN: res_d = {~b_sign, a_mag};
         NC_SGNJX: res_d = {a_sign ^ b_sign, a_mag};
         NC_MIN, NC_MAX: begin
            if (a_nan & b_nan)  res_d = CANON_NAN;
            else if (a_nan)     res_d = req.opb;
            else if (b_nan)     res_d = req.opa;
            else if (lt_tot ^ (req.noncomp_op == NC_MAX)) res_d = req.opa;
            else                res_d = req.opb;
         end
         NC_EQ:    res_d = XLEN'(feq);
         NC_LT:    res_d = XLEN'(flt);
         NC_LE:    res_d = XLEN'(fle);
         NC_CLASS: res_d = XLEN'(class_mask);
         default:  res_d = req.opa;   // Register moves copy rs1
      endcase
   end

   always_ff @(posedge clk_i, negedge rstn_i) begin
      if (!rstn_i) begin
         result_o <= '0;
      end else if (req.start && req.op_class != OPC_MUL) begin
         result_o <= res_d;
      end
   end

endmodule

`default_nettype wire

//--- fpu_ctrl_fsm.sv
/*
 * Control FSM for one instruction in flight.
 * in_ready_o is high only in IDLE. Kill wins over every other event.
 * Noncomp results are ready right after accept, FMUL after its last step.
 */
`timescale 1ns/1ns
`default_nettype none

module fpu_ctrl_fsm import fpu_pkg::*; (
   input  logic    clk_i,
   input  logic    rstn_i,
   input  logic    in_valid_i,
   output logic    in_ready_o,
   output logic    out_valid_o,
   input  logic    out_ready_i,
   input  logic    kill_i,
   fpu_req_if.ctrl req,
   input  logic    step_last_i,
   input  logic    mul_done_i,
   output logic    count_en_o,
   output logic    sel_mul_o
);

   ctrl_state_e state_q, state_d;
   logic        accept;

   assign in_ready_o  = (state_q == ST_IDLE);
   assign accept      = in_ready_o & in_valid_i & ~kill_i;
   assign out_valid_o = (state_q == ST_HOLD);
   assign count_en_o  = (state_q == ST_RUN);

   assign req.start = accept;
   assign req.kill  = kill_i;

   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_IDLE: begin
            if (accept) begin
               state_d = (req.op_class == OPC_MUL) ? ST_RUN : ST_HOLD;
            end
         end
         ST_RUN: begin
            if (mul_done_i) begin
               state_d = ST_HOLD;
            end
         end
         ST_HOLD: if (out_ready_i) state_d = ST_IDLE;   // Retire
         default: state_d = ST_IDLE;
      endcase
      if (kill_i) state_d = ST_IDLE;
   end

   always_ff @(posedge clk_i, negedge rstn_i) begin
      if (!rstn_i) begin
         state_q   <= ST_IDLE;
         sel_mul_o <= 1'b0;
      end else begin
         state_q <= state_d;
         if (accept) sel_mul_o <= (req.op_class == OPC_MUL);   // Output source
      end
   end

endmodule

`default_nettype wire

//--- fpu_step_counter.sv
/*
 * Iteration counter for the shift-add multiplier.
 * last_o marks the final step. The count wraps to zero after it.
 */
`timescale 1ns/1ns
`default_nettype none

module fpu_step_counter import fpu_pkg::*; (
   input  logic clk_i,
   input  logic rstn_i,
   input  logic clear_i,       // New instruction or kill
   input  logic count_en_i,
   output logic last_o
);

   logic [MUL_CNT_W-1:0] cnt_q;

   assign last_o = (cnt_q == MUL_CNT_W'(MUL_STEPS - 1));

   always_ff @(posedge clk_i, negedge rstn_i) begin
      if (!rstn_i) begin
         cnt_q <= '0;
      end else if (clear_i) begin
         cnt_q <= '0;
      end else if (count_en_i) begin
         cnt_q <= last_o ? '0 : cnt_q + 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- fpu_decoder.sv
/*
 * Maps the issued FP instruction type to class, sub-operation and target
 * register file. Unknown types fall back to a plain move, which is harmless
 * because the issue side never presents them as valid.
 */
`timescale 1ns/1ns
`default_nettype none

module fpu_decoder import fpu_pkg::*; (
   input  instr_type_e    instr_type_i,
   fpu_req_if.dec         req
);

   always_comb begin
      req.op_class   = OPC_NONCOMP;
      req.noncomp_op = NC_MV_X2F;
      req.int_dest   = 1'b0;

      case (instr_type_i)
         // Sign injection
         FSGNJ:   req.noncomp_op = NC_SGNJ;
         FSGNJN:  req.noncomp_op = NC_SGNJN;
         FSGNJX:  req.noncomp_op = NC_SGNJX;
         FMIN:    req.noncomp_op = NC_MIN;
         FMAX:    req.noncomp_op = NC_MAX;

         // Compares and classify write the integer file
         FEQ: begin
            req.noncomp_op = NC_EQ;
            req.int_dest   = 1'b1;
         end
         FLT: begin
            req.noncomp_op = NC_LT;
            req.int_dest   = 1'b1;
         end
         FLE: begin
            req.noncomp_op = NC_LE;
            req.int_dest   = 1'b1;
         end
         FCLASS: begin
            req.noncomp_op = NC_CLASS;
            req.int_dest   = 1'b1;
         end

         FMV_X2F: req.op_class = OPC_MOVE;
         FMV_F2X: begin
            req.op_class   = OPC_MOVE;
            req.noncomp_op = NC_MV_F2X;
            req.int_dest   = 1'b1;
         end

         FMUL:    req.op_class = OPC_MUL;   // Sub-operation unused

         default: req.op_class = OPC_MOVE;
      endcase
   end

endmodule

`default_nettype wire

//--- fpu_req_if.sv
/*
 * Decoded request bundle between decoder, control FSM and datapaths.
 * Operands are raw bit patterns. start is a single-cycle accept pulse.
 */
`timescale 1ns/1ns
`default_nettype none

interface fpu_req_if import fpu_pkg::*; ();

   op_class_e       op_class;
   noncomp_op_e     noncomp_op;
   logic            int_dest;     // Result goes to the integer file
   logic [XLEN-1:0] opa;
   logic [XLEN-1:0] opb;
   logic            start;
   logic            kill;

   modport dec  (output op_class, output noncomp_op, output int_dest);

   modport ctrl (input op_class, output start, output kill);

   // Datapaths only observe the request
   modport dp   (input op_class, input noncomp_op, input opa, input opb,
                 input start, input kill);

endinterface

`default_nettype wire

//--- fpu_pkg.sv
/*
 * Shared types and constants for the scalar FP32 execute stage.
 * Single precision only. There is no format field and no FP64 support.
 * Enum encodings are internal and do not follow the RISC-V opcode map.
 */
`default_nettype none

package fpu_pkg;

   // ------------------------------
   // Widths and constants
   // ------------------------------
   localparam int XLEN      = 32;          // Operand and result width
   localparam int FLEN      = 32;
   localparam int EXP_W     = 8;
   localparam int MAN_W     = 23;
   localparam int EXP_BIAS  = 127;
   localparam int CLASS_W   = 10;          // FCLASS mask width

   localparam int MUL_STEPS = MAN_W + 1;   // One step per multiplier bit
   localparam int MUL_CNT_W = $clog2(MUL_STEPS);

   localparam logic [FLEN-1:0] CANON_NAN = 32'h7fc0_0000;

   // ------------------------------
   // Instruction and operation types
   // ------------------------------
   typedef enum logic [3:0] {
      INSTR_NONE,
      FSGNJ,
      FSGNJN,
      FSGNJX,
      FMIN,
      FMAX,
      FEQ,
      FLT,
      FLE,
      FCLASS,
      FMV_X2F,
      FMV_F2X,
      FMUL
   } instr_type_e;

   typedef enum logic [1:0] {
      OPC_NONCOMP,
      OPC_MUL,
      OPC_MOVE
   } op_class_e;

   typedef enum logic [3:0] {
      NC_SGNJ,
      NC_SGNJN,
      NC_SGNJX,
      NC_MIN,
      NC_MAX,
      NC_EQ,
      NC_LT,
      NC_LE,
      NC_CLASS,
      NC_MV_X2F,
      NC_MV_F2X
   } noncomp_op_e;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_RUN,
      ST_HOLD
   } ctrl_state_e;

endpackage

`default_nettype wire
